/* all.f */
hw/adder_pkg.sv
hw/stream_if.sv
hw/pipe_stage.sv
hw/knowles_adder.sv
hw/add_unit.sv
hw/adder_top.sv
dv/adder_props.sv
dv/tb_adder.sv

/* Makefile */
# Verilator build and run for the significand adder testbench

all: run

obj_dir/Vtb_adder: all.f $(wildcard hw/*.sv dv/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_adder -f all.f

.PHONY: all run clean

# Fails unless the pass message shows up in the simulation output
run: obj_dir/Vtb_adder
	@out="$$(./obj_dir/Vtb_adder)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* dv/tb_adder.sv */
// Testbench for the adder top level with directed, random and back-pressure tests
`timescale 1ns/1ns
`default_nettype none

module tb_adder
	import adder_pkg::*;
();

	logic             clk;
	logic             rst_n;
	logic             in_valid;
	logic             in_ready;
	add_op_t          in_op;
	logic [tag_w-1:0] in_tag;
	logic [sig_w-1:0] in_a;
	logic [sig_w-1:0] in_b;
	logic             out_valid;
	logic             out_ready;
	logic [tag_w-1:0] out_tag;
	logic [sig_w-1:0] out_sum;
	logic             out_cout;
	logic             out_zero;

	add_req_t    req_q[$];
	add_rsp_t    rsp_q[$];
	int          errors;
	int          checks;
	int          tests;
	int          test_errors;
	bit          timed_out;
	logic [31:0] lcg_state;

	// Snapshot taken when out_ready is released
	int   held_count;
	logic held_ready;
	logic held_valid;

	adder_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_op     (in_op),
		.in_tag    (in_tag),
		.in_a      (in_a),
		.in_b      (in_b),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_tag   (out_tag),
		.out_sum   (out_sum),
		.out_cout  (out_cout),
		.out_zero  (out_zero)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Subtract as a + ~b + 1
	// cout is bit 24 of the total
	function automatic add_rsp_t model_rsp(input add_req_t r);
		logic [sig_w:0] total;
		add_rsp_t       e;
		if (r.op == op_sub) begin
			total = {1'b0, r.a} + {1'b0, ~r.b} + (sig_w + 1)'(1);
		end else begin
			total = {1'b0, r.a} + {1'b0, r.b};
		end
		e.tag  = r.tag;
		e.sum  = total[sig_w-1:0];
		e.cout = total[sig_w];
		e.zero = (total[sig_w-1:0] == '0);
		return e;
	endfunction

	task automatic check_sum(input string name, input add_rsp_t exp, input add_rsp_t act);
		checks++;
		if (act.tag !== exp.tag || act.sum !== exp.sum) begin
			$display("Error %s: tag/sum expected %h/%h actual %h/%h",
				name, exp.tag, exp.sum, act.tag, act.sum);
			test_errors++;
		end
	endtask

	task automatic check_flags(input string name, input add_rsp_t exp, input add_rsp_t act);
		checks++;
		if (act.cout !== exp.cout || act.zero !== exp.zero) begin
			$display("Error %s: cout/zero expected %b/%b actual %b/%b",
				name, exp.cout, exp.zero, act.cout, act.zero);
			test_errors++;
		end
	endtask

	task automatic check_level(input string name, input string what, input logic exp,
		input logic act);
		checks++;
		if (act !== exp) begin
			$display("Error %s: %s expected %b actual %b", name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic queue_req(input add_op_t op, input logic [sig_w-1:0] a,
		input logic [sig_w-1:0] b);
		add_req_t r;
		r.op  = op;
		r.tag = tag_w'(req_q.size());
		r.a   = a;
		r.b   = b;
		req_q.push_back(r);
	endtask

	// Runs from one falling edge to another
	// out_ready stays low for the first stall cycles
	task automatic stream_batch(input string name, input int stall);
		int       idx;
		int       timer;
		int       limit;
		add_rsp_t got;
		idx   = 0;
		timer = 0;
		limit = 4 * req_q.size() + stall + 20;
		rsp_q.delete();
		while ((idx < req_q.size() || rsp_q.size() < req_q.size()) && timer < limit) begin
			if (stall > 0 && timer == stall) begin
				held_count = idx;
				held_ready = in_ready;
				held_valid = out_valid;
			end
			if (idx < req_q.size()) begin
				in_valid = 1'b1;
				in_op    = req_q[idx].op;
				in_tag   = req_q[idx].tag;
				in_a     = req_q[idx].a;
				in_b     = req_q[idx].b;
			end else begin
				in_valid = 1'b0;
			end
			out_ready = (timer >= stall);
			@(posedge clk);
			if (in_valid && in_ready) begin
				idx++;
			end
			if (out_valid && out_ready) begin
				got = '{tag: out_tag, sum: out_sum, cout: out_cout, zero: out_zero};
				rsp_q.push_back(got);
			end
			@(negedge clk);
			timer++;
		end
		in_valid = 1'b0;
		if (rsp_q.size() < req_q.size()) begin
			$display("%s: DUT stopped responding, got %0d of %0d results",
				name, rsp_q.size(), req_q.size());
			timed_out = 1'b1;
			test_errors++;
		end else begin
			for (int i = 0; i < req_q.size(); i++) begin
				check_sum(name, model_rsp(req_q[i]), rsp_q[i]);
				check_flags(name, model_rsp(req_q[i]), rsp_q[i]);
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		errors += test_errors;
		$display("Test %s finished with %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	task automatic idle_after_reset();
		check_level("reset_state", "out_valid", 1'b0, out_valid);
		check_level("reset_state", "in_ready", 1'b1, in_ready);
		finish_test("reset_state");
	endtask

	task automatic directed_adds();
		req_q.delete();
		queue_req(op_add, 24'hff_ffff, 24'h00_0001);
		queue_req(op_add, 24'h7f_ffff, 24'h00_0001);
		queue_req(op_add, 24'h00_0000, 24'h00_0000);
		queue_req(op_add, 24'haa_aaaa, 24'h55_5555);
		queue_req(op_add, 24'hff_ffff, 24'hff_ffff);
		queue_req(op_add, 24'h80_0000, 24'h80_0000);
		queue_req(op_add, 24'h12_3456, 24'h65_4321);
		stream_batch("directed_add", 0);
		finish_test("directed_add");
	endtask

	task automatic directed_subs();
		req_q.delete();
		queue_req(op_sub, 24'h12_3456, 24'h12_3456);
		queue_req(op_sub, 24'h00_0001, 24'h00_0002);
		queue_req(op_sub, 24'h00_0000, 24'h00_0000);
		queue_req(op_sub, 24'h80_0000, 24'h00_0001);
		queue_req(op_sub, 24'h00_0000, 24'hff_ffff);
		queue_req(op_sub, 24'hff_ffff, 24'h00_0001);
		stream_batch("directed_sub", 0);
		finish_test("directed_sub");
	endtask

	task automatic random_ops();
		logic [sig_w-1:0] a;
		logic [sig_w-1:0] b;
		req_q.delete();
		for (int i = 0; i < 200; i++) begin
			lcg_state = lcg_next(lcg_state);
			a         = lcg_state[31:8];
			lcg_state = lcg_next(lcg_state);
			b         = lcg_state[31:8];
			lcg_state = lcg_next(lcg_state);
			queue_req(add_op_t'(lcg_state[31]), a, b);
		end
		stream_batch("random", 0);
		finish_test("random");
	endtask

	// Two slices hold two items and the third waits
	task automatic stall_and_release();
		req_q.delete();
		queue_req(op_add, 24'h00_0010, 24'h00_0020);
		queue_req(op_sub, 24'h00_0100, 24'h00_0200);
		queue_req(op_add, 24'hff_ffff, 24'h00_0001);
		queue_req(op_sub, 24'h55_5555, 24'h55_5555);
		stream_batch("backpressure", 6);
		checks++;
		if (held_count != 2) begin
			$display("Error backpressure: accepted while stalled expected 2 actual %0d",
				held_count);
			test_errors++;
		end
		check_level("backpressure", "in_ready while stalled", 1'b0, held_ready);
		check_level("backpressure", "out_valid while stalled", 1'b1, held_valid);
		finish_test("backpressure");
	endtask

	initial begin
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_op       = op_add;
		in_tag      = '0;
		in_a        = '0;
		in_b        = '0;
		out_ready   = 1'b0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		test_errors = 0;
		timed_out   = 1'b0;
		held_count  = 0;
		held_ready  = 1'b0;
		held_valid  = 1'b0;
		lcg_state   = 32'h00a7_e41c;

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		idle_after_reset();
		if (!timed_out) begin
			directed_adds();
		end
		if (!timed_out) begin
			directed_subs();
		end
		if (!timed_out) begin
			random_ops();
		end
		if (!timed_out) begin
			stall_and_release();
		end

		$display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/adder_props.sv */
// Adder properties, handshake and reset assertions bound to the adder top level
`timescale 1ns/1ns
`default_nettype none

module adder_props
	import adder_pkg::*;
(
	input logic             clk,
	input logic             rst_n,
	input logic             in_ready,
	input logic             out_valid,
	input logic             out_ready,
	input logic [tag_w-1:0] out_tag,
	input logic [sig_w-1:0] out_sum,
	input logic             out_cout,
	input logic             out_zero
);

	// Output slice is empty while reset is held
	reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	// Stalled result stays put
	hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=>
			out_valid && $stable({out_tag, out_sum, out_cout, out_zero}))
		else $error("output payload changed while stalled");

	empty_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> in_ready)
		else $error("in_ready low with the output slice empty");

endmodule

bind adder_top adder_props u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_tag   (out_tag),
	.out_sum   (out_sum),
	.out_cout  (out_cout),
	.out_zero  (out_zero)
);

`default_nettype wire

/* hw/adder_top.sv */
// Significand add/subtract top level with input and output register slices
`timescale 1ns/1ns
`default_nettype none

module adder_top
	import adder_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,

	input  logic             in_valid,
	output logic             in_ready,
	input  add_op_t          in_op,
	input  logic [tag_w-1:0] in_tag,
	input  logic [sig_w-1:0] in_a,
	input  logic [sig_w-1:0] in_b,

	output logic             out_valid,
	input  logic             out_ready,
	output logic [tag_w-1:0] out_tag,
	output logic [sig_w-1:0] out_sum,
	output logic             out_cout,
	output logic             out_zero
);

	add_rsp_t out_d;

	stream_if #(.payload_t(add_req_t)) in_s ();
	stream_if #(.payload_t(add_req_t)) req_s ();
	stream_if #(.payload_t(add_rsp_t)) rsp_s ();
	stream_if #(.payload_t(add_rsp_t)) out_s ();

	// Request side
	assign in_s.valid   = in_valid;
	assign in_s.payload = '{op: in_op, tag: in_tag, a: in_a, b: in_b};
	assign in_ready     = in_s.ready;

	pipe_stage #(
		.payload_t(add_req_t)
	) u_in_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.up    (in_s.consumer),
		.dn    (req_s.producer)
	);

	add_unit u_add_unit (
		.req (req_s.consumer),
		.rsp (rsp_s.producer)
	);

	pipe_stage #(
		.payload_t(add_rsp_t)
	) u_out_stage (
		.clk   (clk),
		.rst_n (rst_n),
		.up    (rsp_s.consumer),
		.dn    (out_s.producer)
	);

	// Response side
	assign out_d       = out_s.payload;
	assign out_s.ready = out_ready;
	assign out_valid   = out_s.valid;
	assign out_tag     = out_d.tag;
	assign out_sum     = out_d.sum;
	assign out_cout    = out_d.cout;
	assign out_zero    = out_d.zero;

endmodule

`default_nettype wire

/* hw/add_unit.sv */
// Add unit, conditions operands for add/subtract and forms the response flags
`timescale 1ns/1ns
`default_nettype none

module add_unit
	import adder_pkg::*;
(
	stream_if.consumer req,
	stream_if.producer rsp
);

	add_req_t         req_d;
	add_rsp_t         rsp_d;
	logic             sub;
	logic [sig_w-1:0] b_in;
	logic [sig_w-1:0] sum;
	logic             cout;

	assign req_d = req.payload;

	// Two's complement subtract, carry-in supplies the +1
	assign sub  = (req_d.op == op_sub);
	assign b_in = sub ? ~req_d.b : req_d.b;

	knowles_adder #(
		.width(sig_w)
	) u_adder (
		.a    (req_d.a),
		.b    (b_in),
		.cin  (sub),
		.sum  (sum),
		.cout (cout)
	);

	assign rsp_d.tag  = req_d.tag;
	assign rsp_d.sum  = sum;
	assign rsp_d.cout = cout;
	assign rsp_d.zero = ~|sum;

	assign rsp.payload = rsp_d;

	// No state here, handshake goes straight through
	assign rsp.valid = req.valid;
	assign req.ready = rsp.ready;

endmodule

`default_nettype wire

/* hw/knowles_adder.sv */
// Knowles parallel-prefix adder using Ling pseudo-carries, purely combinational
`timescale 1ns/1ns
`default_nettype none

module knowles_adder #(
	parameter int width = 24
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             cin,
	output logic [width-1:0] sum,
	output logic             cout
);

	// width+1 prefix positions, position 0 holds the carry-in
	localparam int stages = $clog2(width + 1);
	localparam int d_last = 1 << (stages - 1);

	logic [width:0] p;
	logic [width:0] g;
	logic [width:0] hc;
	logic [width:1] c;

	// First stage cell, g_lo already implies the shifted propagate
	function automatic logic [1:0] reduced_cell(
		input logic g_hi,
		input logic g_lo,
		input logic t_hi,
		input logic t_lo
	);
		return {g_hi | g_lo, t_hi & t_lo};
	endfunction

	function automatic logic [1:0] black_cell(
		input logic h_hi,
		input logic t_hi,
		input logic h_lo,
		input logic t_lo
	);
		return {h_hi | (t_hi & h_lo), t_hi & t_lo};
	endfunction

	// Span reaches position 0, no group propagate needed
	function automatic logic grey_cell(
		input logic h_hi,
		input logic t_hi,
		input logic h_lo
	);
		return h_hi | (t_hi & h_lo);
	endfunction

	assign p = {a | b, 1'b1};
	assign g = {a & b, cin};

	// Level s node i spans [i : i-2^s+1]
	// t is the Ling propagate, shifted down by one position
	for (genvar s = 0; s < stages; s++) begin : g_lvl
		logic [width:0] h;
		logic [width:0] t;

		if (s == 0) begin : g_pre
			assign h = g;
			assign t = {p[width-1:0], 1'b0};
		end else begin : g_tree
			localparam int d = 1 << (s - 1);

			for (genvar i = 0; i <= width; i++) begin : g_node
				if (i < d) begin : g_pass
					assign h[i] = g_lvl[s-1].h[i];
					assign t[i] = 1'b0;
				end else if (s == 1) begin : g_reduced
					assign {h[i], t[i]} = reduced_cell(g_lvl[0].h[i], g_lvl[0].h[i-1],
						g_lvl[0].t[i], g_lvl[0].t[i-1]);
				end else if (i < 2 * d) begin : g_grey
					assign h[i] = grey_cell(g_lvl[s-1].h[i], g_lvl[s-1].t[i],
						g_lvl[s-1].h[i-d]);
					assign t[i] = 1'b0;
				end else begin : g_black
					assign {h[i], t[i]} = black_cell(g_lvl[s-1].h[i], g_lvl[s-1].t[i],
						g_lvl[s-1].h[i-d], g_lvl[s-1].t[i-d]);
				end
			end
		end
	end

	// Last stage at fanout two
	// overlapping spans are harmless since the Ling cells are idempotent
	for (genvar i = 0; i <= width; i++) begin : g_last
		if (i < d_last) begin : g_pass
			assign hc[i] = g_lvl[stages-1].h[i];
		end else begin : g_grey
			assign hc[i] = grey_cell(g_lvl[stages-1].h[i], g_lvl[stages-1].t[i],
				g_lvl[stages-1].h[(i - d_last) | 1]);
		end
	end

	// True carry into position j is p[j-1] & H[j-1:0]
	assign c = p[width-1:0] & hc[width-1:0];

	// hc[j] = g[j] | c[j], so this gives a^b^carry without a separate xor of a and b
	assign sum  = (p[width:1] ^ hc[width:1]) | (g[width:1] & c);
	assign cout = p[width] & hc[width];

endmodule

`default_nettype wire

/* hw/pipe_stage.sv */
// Pipe stage, a one-entry valid/ready register slice for any payload type
`timescale 1ns/1ns
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic        clk,
	input  logic        rst_n,
	stream_if.consumer  up,
	stream_if.producer  dn
);

	logic     full;
	logic     load;
	logic     drain;
	payload_t data;

	// Ready when empty, or when the held item leaves on this edge
	assign up.ready = !full || dn.ready;

	assign load  = up.valid && up.ready;
	assign drain = full && dn.ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;
		end else if (drain) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			data <= up.payload;
		end
	end

	assign dn.valid   = full;
	assign dn.payload = data;

endmodule

`default_nettype wire

/* hw/stream_if.sv */
// Valid/ready stream interface carrying a typed payload
`timescale 1ns/1ns
`default_nettype none

interface stream_if #(
	parameter type payload_t = logic
);

	logic     valid;
	logic     ready;
	payload_t payload;

	// Producer holds valid and payload until the transfer edge
	modport producer (
		output valid,
		output payload,
		input  ready
	);

	modport consumer (
		input  valid,
		input  payload,
		output ready
	);

endinterface

`default_nettype wire

/* hw/adder_pkg.sv */
// Adder package with the significand datapath width, operation code and stream payloads
`default_nettype none

package adder_pkg;

	// Single-precision significand including the hidden bit
	localparam int sig_w = 24;

	localparam int tag_w = 4;

	// Subtract is a + ~b + 1
	typedef enum logic {
		op_add = 1'b0,
		op_sub = 1'b1
	} add_op_t;

	// Request, 53 bits
	typedef struct packed {
		add_op_t          op;
		logic [tag_w-1:0] tag;
		logic [sig_w-1:0] a;
		logic [sig_w-1:0] b;
	} add_req_t;

	// Response, 30 bits
	// On a subtract, cout high means no borrow
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [sig_w-1:0] sum;
		logic             cout;
		logic             zero;
	} add_rsp_t;

endpackage

`default_nettype wire
